/* logic/vga_text_pkg.sv */
package vga_text_pkg;

    ////////////////////////////////////////
    // address regions
    ////////////////////////////////////////

    // top nibble of the 30-bit word address
    // anything below c counts as main memory
    typedef enum logic [3:0] {
        REGION_MAIN   = 4'h0,
        REGION_VMEM   = 4'hc,
        REGION_TIMER  = 4'hd,
        REGION_KBD    = 4'he,
        REGION_LOADER = 4'hf
    } region_t;

    // store data from the register file
    // lane 0 is the most significant byte
    typedef union packed {
        logic [31:0]     word;
        logic [0:3][7:0] lane;
    } store_word_u;

    ////////////////////////////////////////
    // display widths and colours
    ////////////////////////////////////////

    localparam int CHAR_W  = 8;
    localparam int CELL_PX = 8;
    localparam int COLOR_W = 4;

    // light green text
    localparam logic [COLOR_W-1:0] FG_R = 4'h2;
    localparam logic [COLOR_W-1:0] FG_G = 4'hf;
    localparam logic [COLOR_W-1:0] FG_B = 4'h4;

    // dark blue backdrop
    localparam logic [COLOR_W-1:0] BG_R = 4'h0;
    localparam logic [COLOR_W-1:0] BG_G = 4'h1;
    localparam logic [COLOR_W-1:0] BG_B = 4'h5;

endpackage

/* logic/vmem_wr_if.sv */
`timescale 1ns/1ps

interface vmem_wr_if #(
    parameter int VMEM_ADDR_W = 10
);
    import vga_text_pkg::*;

    // level, high while a store to region c is on the port
    logic                   wr_req;
    // registered strobe from the sequencer
    logic                   wr_en;
    // byte address of the character cell
    logic [VMEM_ADDR_W-1:0] cell_addr;
    logic [CHAR_W-1:0]      char_code;

    // decoder side
    modport source (output wr_req, output cell_addr, output char_code);

    // write sequencer
    modport sequencer (input wr_req, output wr_en);

    // character memory write port
    modport sink (input wr_en, input cell_addr, input char_code);

endinterface

/* logic/mem_port_decode.sv */
`timescale 1ns/1ps

module mem_port_decode #(
    parameter int VMEM_ADDR_W = 10
) (
    input  logic [29:0]               dmem_addr,
    input  logic                      dmem_read,
    input  logic                      dmem_write,
    input  logic [3:0]                byte_en,
    input  vga_text_pkg::store_word_u store_data,
    input  logic [15:0]               frame_count,
    input  logic                      seq_busy,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic [31:0]               load_data,
    output logic                      mem_stall,
    vmem_wr_if.source                 wr
);
    import vga_text_pkg::*;

    region_t    region;
    logic [1:0] lane_sel;

    ////////////////////////////////////////
    // region decode
    ////////////////////////////////////////

    always_comb begin
        case (dmem_addr[29:26])
            4'hc:    region = REGION_VMEM;
            4'hd:    region = REGION_TIMER;
            4'he:    region = REGION_KBD;
            4'hf:    region = REGION_LOADER;
            default: region = REGION_MAIN;
        endcase
    end

    // main memory only, everything else stays local
    assign mem_read  = dmem_read && (region == REGION_MAIN);
    assign mem_write = dmem_write && (region == REGION_MAIN);

    // timer load gets the frame count, keyboard and loader read as zero
    assign load_data = (dmem_read && (region == REGION_TIMER)) ? {16'h0000, frame_count}
                                                                : 32'h0000_0000;

    ////////////////////////////////////////
    // video memory store
    ////////////////////////////////////////

    // single-hot enable picks offset and lane
    always_comb begin
        case (byte_en)
            4'b1000: lane_sel = 2'd0;
            4'b0100: lane_sel = 2'd1;
            4'b0010: lane_sel = 2'd2;
            4'b0001: lane_sel = 2'd3;
            // malformed enable, treat as lane 3
            default: lane_sel = 2'd3;
        endcase
    end

    assign wr.wr_req    = dmem_write && (region == REGION_VMEM);
    // word address plus byte offset
    assign wr.cell_addr = {dmem_addr[VMEM_ADDR_W-3:0], lane_sel};
    assign wr.char_code = store_data.lane[lane_sel];

    // held until the sequencer reaches release
    assign mem_stall = wr.wr_req && seq_busy;

endmodule

/* logic/vmem_write_fsm.sv */
`timescale 1ns/1ps

module vmem_write_fsm (
    input  logic         pixel_clk,
    input  logic         rst,
    vmem_wr_if.sequencer wr,
    output logic         busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_FIRST,
        ST_WRITE_SECOND,
        ST_RELEASE
    } state_t;

    state_t state;
    state_t state_next;

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////

    always_ff @(posedge pixel_clk) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (wr.wr_req) begin
                    state_next = ST_WRITE_FIRST;
                end
            end
            ST_WRITE_FIRST:  state_next = ST_WRITE_SECOND;
            ST_WRITE_SECOND: state_next = ST_RELEASE;
            ST_RELEASE: begin
                // pipeline moves on, wait for the request to go away
                if (!wr.wr_req) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    // write enable straight from state flops, two edges of writing
    assign wr.wr_en = (state == ST_WRITE_FIRST) || (state == ST_WRITE_SECOND);

    // stall covers request cycle plus both write cycles
    assign busy = ((state == ST_IDLE) && wr.wr_req) || wr.wr_en;

endmodule

/* logic/video_timing.sv */
`timescale 1ns/1ps

module video_timing #(
    parameter int H_DISP  = 64,
    parameter int H_FRONT = 4,
    parameter int H_SYNC  = 8,
    parameter int H_BACK  = 4,
    parameter int V_DISP  = 32,
    parameter int V_FRONT = 1,
    parameter int V_SYNC  = 2,
    parameter int V_BACK  = 1
) (
    input  logic        pixel_clk,
    input  logic        rst,
    output logic [10:0] h_pos,
    output logic [10:0] v_pos,
    output logic        active,
    output logic        hsync,
    output logic        vsync,
    output logic [15:0] frame_count
);

    localparam int H_TOTAL = H_DISP + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_DISP + V_FRONT + V_SYNC + V_BACK;

    // sync pulse sits between front and back porch
    localparam logic [10:0] H_SYNC_START = 11'(H_DISP + H_FRONT);
    localparam logic [10:0] H_SYNC_END   = 11'(H_DISP + H_FRONT + H_SYNC);
    localparam logic [10:0] V_SYNC_START = 11'(V_DISP + V_FRONT);
    localparam logic [10:0] V_SYNC_END   = 11'(V_DISP + V_FRONT + V_SYNC);

    logic h_wrap;
    logic v_wrap;

    assign h_wrap = (h_pos == 11'(H_TOTAL - 1));
    assign v_wrap = (v_pos == 11'(V_TOTAL - 1));

    ////////////////////////////////////////
    // scan counters
    ////////////////////////////////////////

    always_ff @(posedge pixel_clk) begin
        if (!rst) begin
            h_pos       <= '0;
            v_pos       <= '0;
            frame_count <= '0;
        end else if (h_wrap) begin
            h_pos <= '0;
            if (v_wrap) begin
                v_pos       <= '0;
                // one full frame done
                frame_count <= frame_count + 16'd1;
            end else begin
                v_pos <= v_pos + 11'd1;
            end
        end else begin
            h_pos <= h_pos + 11'd1;
        end
    end

    assign active = (h_pos < 11'(H_DISP)) && (v_pos < 11'(V_DISP));

    // active-low pulses
    assign hsync = !((h_pos >= H_SYNC_START) && (h_pos < H_SYNC_END));
    assign vsync = !((v_pos >= V_SYNC_START) && (v_pos < V_SYNC_END));

endmodule

/* logic/text_vmem.sv */
`timescale 1ns/1ps

module text_vmem #(
    parameter int VMEM_ADDR_W = 10
) (
    input  logic                            pixel_clk,
    vmem_wr_if.sink                         wr,
    input  logic [VMEM_ADDR_W-1:0]          rd_addr,
    output logic [vga_text_pkg::CHAR_W-1:0] rd_char
);
    import vga_text_pkg::*;

    localparam int DEPTH = 2 ** VMEM_ADDR_W;

    // one byte per character cell
    // blank screen at power-up
    logic [CHAR_W-1:0] cells [DEPTH] = '{default: '0};

    ////////////////////////////////////////
    // pipeline write port
    ////////////////////////////////////////

    // enable from the sequencer, address and code
    // held stable by the stalled pipeline
    always_ff @(posedge pixel_clk) begin
        if (wr.wr_en) begin
            cells[wr.cell_addr] <= wr.char_code;
        end
    end

    ////////////////////////////////////////
    // scan read port
    ////////////////////////////////////////

    // registered read, one cycle behind the counters
    always_ff @(posedge pixel_clk) begin
        rd_char <= cells[rd_addr];
    end

endmodule

/* logic/glyph_render.sv */
`timescale 1ns/1ps

module glyph_render (
    input  logic                             pixel_clk,
    input  logic                             rst,
    input  logic [vga_text_pkg::CHAR_W-1:0]  rd_char,
    input  logic [2:0]                       col_bit,
    input  logic                             active_d,
    input  logic                             hsync_d,
    input  logic                             vsync_d,
    output logic [vga_text_pkg::COLOR_W-1:0] vga_r,
    output logic [vga_text_pkg::COLOR_W-1:0] vga_g,
    output logic [vga_text_pkg::COLOR_W-1:0] vga_b,
    output logic                             vga_hs,
    output logic                             vga_vs
);
    import vga_text_pkg::*;

    logic pixel_on;

    // column k shows bit 7-k of the code
    // for a 3-bit column that is just the complement
    assign pixel_on = rd_char[~col_bit];

    ////////////////////////////////////////
    // output stage
    ////////////////////////////////////////

    always_ff @(posedge pixel_clk) begin
        if (!rst) begin
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
        end else begin
            // sync follows colour through the same register
            vga_hs <= hsync_d;
            vga_vs <= vsync_d;
            if (!active_d) begin
                // blanking is black
                vga_r <= '0;
                vga_g <= '0;
                vga_b <= '0;
            end else if (pixel_on) begin
                vga_r <= FG_R;
                vga_g <= FG_G;
                vga_b <= FG_B;
            end else begin
                vga_r <= BG_R;
                vga_g <= BG_G;
                vga_b <= BG_B;
            end
        end
    end

endmodule

/* logic/vga_text_top.sv */
`timescale 1ns/1ps

module vga_text_top #(
    parameter int VMEM_ADDR_W = 10,
    parameter int H_DISP      = 64,
    parameter int H_FRONT     = 4,
    parameter int H_SYNC      = 8,
    parameter int H_BACK      = 4,
    parameter int V_DISP      = 32,
    parameter int V_FRONT     = 1,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 1
) (
    input  logic                             pixel_clk,
    input  logic                             rst,
    input  logic [29:0]                      dmem_addr,
    input  logic                             dmem_read,
    input  logic                             dmem_write,
    input  logic [3:0]                       byte_en,
    input  logic [31:0]                      store_data,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic [31:0]                      load_data,
    output logic                             mem_stall,
    output logic [vga_text_pkg::COLOR_W-1:0] vga_r,
    output logic [vga_text_pkg::COLOR_W-1:0] vga_g,
    output logic [vga_text_pkg::COLOR_W-1:0] vga_b,
    output logic                             vga_hs,
    output logic                             vga_vs
);
    import vga_text_pkg::*;

    localparam int CELL_SHIFT = $clog2(CELL_PX);
    // character cells per text row
    localparam int COLS = H_DISP / CELL_PX;

    store_word_u            store_word;
    logic [15:0]            frame_count;
    logic                   seq_busy;
    logic [10:0]            h_pos;
    logic [10:0]            v_pos;
    logic [10:0]            cell_row;
    logic [10:0]            cell_col;
    logic                   active;
    logic                   hsync;
    logic                   vsync;
    logic                   active_d;
    logic                   hsync_d;
    logic                   vsync_d;
    logic [2:0]             col_bit_d;
    logic [VMEM_ADDR_W-1:0] rd_addr;
    logic [CHAR_W-1:0]      rd_char;

    vmem_wr_if #(.VMEM_ADDR_W(VMEM_ADDR_W)) vmem_wr ();

    assign store_word.word = store_data;

    ////////////////////////////////////////
    // pipeline side
    ////////////////////////////////////////

    mem_port_decode #(
        .VMEM_ADDR_W (VMEM_ADDR_W)
    ) u_mem_port_decode (
        .dmem_addr   (dmem_addr),
        .dmem_read   (dmem_read),
        .dmem_write  (dmem_write),
        .byte_en     (byte_en),
        .store_data  (store_word),
        .frame_count (frame_count),
        .seq_busy    (seq_busy),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .load_data   (load_data),
        .mem_stall   (mem_stall),
        .wr          (vmem_wr)
    );

    vmem_write_fsm u_vmem_write_fsm (
        .pixel_clk (pixel_clk),
        .rst       (rst),
        .wr        (vmem_wr),
        .busy      (seq_busy)
    );

    ////////////////////////////////////////
    // scan side
    ////////////////////////////////////////

    video_timing #(
        .H_DISP  (H_DISP),
        .H_FRONT (H_FRONT),
        .H_SYNC  (H_SYNC),
        .H_BACK  (H_BACK),
        .V_DISP  (V_DISP),
        .V_FRONT (V_FRONT),
        .V_SYNC  (V_SYNC),
        .V_BACK  (V_BACK)
    ) u_video_timing (
        .pixel_clk   (pixel_clk),
        .rst         (rst),
        .h_pos       (h_pos),
        .v_pos       (v_pos),
        .active      (active),
        .hsync       (hsync),
        .vsync       (vsync),
        .frame_count (frame_count)
    );

    // row-major cell index, row = v_pos / CELL_PX
    assign cell_row = v_pos >> CELL_SHIFT;
    assign cell_col = h_pos >> CELL_SHIFT;
    assign rd_addr  = VMEM_ADDR_W'(int'(cell_row) * COLS + int'(cell_col));

    text_vmem #(
        .VMEM_ADDR_W (VMEM_ADDR_W)
    ) u_text_vmem (
        .pixel_clk (pixel_clk),
        .wr        (vmem_wr),
        .rd_addr   (rd_addr),
        .rd_char   (rd_char)
    );

    // first delay stage, matches the memory read
    always_ff @(posedge pixel_clk) begin
        if (!rst) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
        end else begin
            active_d <= active;
            hsync_d  <= hsync;
            vsync_d  <= vsync;
        end
    end

    // pixel column within the cell, same delay
    always_ff @(posedge pixel_clk) begin
        col_bit_d <= h_pos[2:0];
    end

    glyph_render u_glyph_render (
        .pixel_clk (pixel_clk),
        .rst       (rst),
        .rd_char   (rd_char),
        .col_bit   (col_bit_d),
        .active_d  (active_d),
        .hsync_d   (hsync_d),
        .vsync_d   (vsync_d),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hs    (vga_hs),
        .vga_vs    (vga_vs)
    );

endmodule

/* sim/vga_text_assertions.sv */
`timescale 1ns/1ps

module vga_text_assertions (
    input logic pixel_clk,
    input logic rst,
    input logic wr_en,
    input logic busy
);

    ////////////////////////////////////////
    // write sequence
    ////////////////////////////////////////

    // two write edges, then enable drops
    property wr_en_two_cycles;
        @(posedge pixel_clk) disable iff (!rst)
            $rose(wr_en) |=> wr_en ##1 !wr_en;
    endproperty

    // stall ends only once both write cycles are over
    property busy_drops_after_writes;
        @(posedge pixel_clk) disable iff (!rst)
            $fell(busy) |-> $past(wr_en) && $past(wr_en, 2);
    endproperty

    // request cycle, then two write cycles, then release
    property busy_three_cycles;
        @(posedge pixel_clk) disable iff (!rst)
            $rose(busy) |-> !wr_en ##1 wr_en ##1 wr_en ##1 !busy;
    endproperty

    a_wr_en_two_cycles: assert property (wr_en_two_cycles)
        else $error("wr_en pulse length is not two cycles");
    a_busy_drops_after_writes: assert property (busy_drops_after_writes)
        else $error("busy dropped before both write cycles were done");
    a_busy_three_cycles: assert property (busy_three_cycles)
        else $error("busy did not cover request plus two write cycles");

endmodule

bind vmem_write_fsm vga_text_assertions u_vga_text_assertions (
    .pixel_clk (pixel_clk),
    .rst       (rst),
    .wr_en     (wr.wr_en),
    .busy      (busy)
);

/* sim/tb_vga_text.sv */
`timescale 1ns/1ps

module tb_vga_text;
    import vga_text_pkg::*;

    ////////////////////////////////////////
    // timing and test sizes
    ////////////////////////////////////////

    localparam int CLK_PERIOD   = 40;
    localparam int VMEM_ADDR_W  = 10;
    localparam int H_DISP       = 64;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 8;
    localparam int H_BACK       = 4;
    localparam int V_DISP       = 32;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int H_TOTAL      = H_DISP + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_DISP + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int COLS         = H_DISP / CELL_PX;
    localparam int N_STORES     = 24;
    localparam int N_MISC       = 24;
    // stores take about six cycles each, scan needs three frames
    localparam int WATCHDOG_CYCLES = N_STORES * 8 + N_MISC * 2 + 3 * FRAME_CYCLES + 2000;

    logic                   pixel_clk;
    logic                   rst;
    logic [29:0]            dmem_addr;
    logic                   dmem_read;
    logic                   dmem_write;
    logic [3:0]             byte_en;
    logic [31:0]            store_data;
    logic                   mem_read;
    logic                   mem_write;
    logic [31:0]            load_data;
    logic                   mem_stall;
    logic [COLOR_W-1:0]     vga_r;
    logic [COLOR_W-1:0]     vga_g;
    logic [COLOR_W-1:0]     vga_b;
    logic                   vga_hs;
    logic                   vga_vs;

    integer                 seed;
    int                     errors;
    int                     checks;
    // model state, shadow of the character memory and scan position
    logic [CHAR_W-1:0]      shadow [2 ** VMEM_ADDR_W];
    int                     scan_cycles = 0;

    vga_text_top #(
        .VMEM_ADDR_W (VMEM_ADDR_W),
        .H_DISP      (H_DISP),
        .H_FRONT     (H_FRONT),
        .H_SYNC      (H_SYNC),
        .H_BACK      (H_BACK),
        .V_DISP      (V_DISP),
        .V_FRONT     (V_FRONT),
        .V_SYNC      (V_SYNC),
        .V_BACK      (V_BACK)
    ) u_vga_text_top (
        .pixel_clk  (pixel_clk),
        .rst        (rst),
        .dmem_addr  (dmem_addr),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .byte_en    (byte_en),
        .store_data (store_data),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .load_data  (load_data),
        .mem_stall  (mem_stall),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b),
        .vga_hs     (vga_hs),
        .vga_vs     (vga_vs)
    );

    initial pixel_clk = 1'b0;
    always #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;

    // cycles since reset release, same count as the scan counters
    always @(posedge pixel_clk) begin
        if (!rst) begin
            scan_cycles <= 0;
        end else begin
            scan_cycles <= scan_cycles + 1;
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_colour(input string name, input logic [COLOR_W-1:0] got,
                                input logic [COLOR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // model helpers
    ////////////////////////////////////////

    // single-hot enable selects the cell offset, anything else is lane 3
    function automatic int lane_offset(input logic [3:0] be);
        case (be)
            4'b1000: return 0;
            4'b0100: return 1;
            4'b0010: return 2;
            default: return 3;
        endcase
    endfunction

    function automatic logic sync_level(input bit vertical);
        return vertical ? vga_vs : vga_hs;
    endfunction

    ////////////////////////////////////////
    // bus operations
    ////////////////////////////////////////

    task automatic release_bus();
        dmem_addr  = '0;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        byte_en    = '0;
        store_data = '0;
    endtask

    task automatic vmem_store(input logic [7:0] word_idx, input logic [3:0] be,
                              input logic [31:0] data);
        int          stall_cycles;
        int          off;
        logic [17:0] upper;
        upper = 18'($random(seed));
        off   = lane_offset(be);
        @(posedge pixel_clk);
        #2;
        dmem_addr  = {REGION_VMEM, upper, word_idx};
        dmem_read  = 1'b0;
        dmem_write = 1'b1;
        byte_en    = be;
        store_data = data;
        @(negedge pixel_clk);
        check_level("mem_write", mem_write, 1'b0);
        stall_cycles = 0;
        // count stalled cycles until release
        while (mem_stall === 1'b1 && stall_cycles < 8) begin
            stall_cycles++;
            @(negedge pixel_clk);
        end
        check_word("mem_stall length", 32'(stall_cycles), 32'd3);
        shadow[{word_idx, 2'(off)}] = data[31 - 8 * off -: 8];
        // pipeline moves on, one idle cycle
        @(posedge pixel_clk);
        #2;
        release_bus();
    endtask

    task automatic main_access();
        logic [3:0]  nib;
        logic [25:0] low;
        logic        is_read;
        nib     = 4'(($random(seed) & 32'h7fff_ffff) % 12);
        low     = 26'($random(seed));
        is_read = 1'($random(seed));
        @(posedge pixel_clk);
        #2;
        dmem_addr  = {nib, low};
        dmem_read  = is_read;
        dmem_write = !is_read;
        byte_en    = 4'b1111;
        store_data = $random(seed);
        @(negedge pixel_clk);
        check_level("mem_read", mem_read, is_read);
        check_level("mem_write", mem_write, !is_read);
        check_level("mem_stall", mem_stall, 1'b0);
    endtask

    task automatic reserved_access();
        logic [3:0]  nib;
        logic [25:0] low;
        logic        is_read;
        nib     = $random(seed) & 1 ? REGION_KBD : REGION_LOADER;
        low     = 26'($random(seed));
        is_read = 1'($random(seed));
        @(posedge pixel_clk);
        #2;
        dmem_addr  = {nib, low};
        dmem_read  = is_read;
        dmem_write = !is_read;
        byte_en    = 4'b0001;
        store_data = $random(seed);
        @(negedge pixel_clk);
        check_level("mem_read", mem_read, 1'b0);
        check_level("mem_write", mem_write, 1'b0);
        check_level("mem_stall", mem_stall, 1'b0);
        check_word("load_data", load_data, 32'h0000_0000);
    endtask

    task automatic timer_load();
        logic [25:0] low;
        low = 26'($random(seed));
        @(posedge pixel_clk);
        #2;
        dmem_addr  = {REGION_TIMER, low};
        dmem_read  = 1'b1;
        dmem_write = 1'b0;
        @(negedge pixel_clk);
        check_word("load_data", load_data, {16'h0000, 16'(scan_cycles / FRAME_CYCLES)});
        check_level("mem_read", mem_read, 1'b0);
        check_level("mem_stall", mem_stall, 1'b0);
        @(posedge pixel_clk);
        #2;
        release_bus();
    endtask

    ////////////////////////////////////////
    // video checks
    ////////////////////////////////////////

    // low time and period of one sync pulse at the ports
    task automatic measure_sync(input bit vertical, input int exp_low, input int exp_period);
        int    low_len;
        int    period;
        int    guard;
        string name;
        name  = vertical ? "vga_vs" : "vga_hs";
        guard = 0;
        @(negedge pixel_clk);
        while (sync_level(vertical) !== 1'b1 && guard < 2 * FRAME_CYCLES) begin
            guard++;
            @(negedge pixel_clk);
        end
        while (sync_level(vertical) !== 1'b0 && guard < 2 * FRAME_CYCLES) begin
            guard++;
            @(negedge pixel_clk);
        end
        if (guard >= 2 * FRAME_CYCLES) begin
            errors++;
            $display("%s never went low within two frames", name);
            return;
        end
        low_len = 0;
        period  = 0;
        while (sync_level(vertical) === 1'b0 && period < 2 * FRAME_CYCLES) begin
            low_len++;
            period++;
            @(negedge pixel_clk);
        end
        while (sync_level(vertical) === 1'b1 && period < 2 * FRAME_CYCLES) begin
            period++;
            @(negedge pixel_clk);
        end
        check_word({name, " low time"}, 32'(low_len), 32'(exp_low));
        check_word({name, " period"}, 32'(period), 32'(exp_period));
    endtask

    // every pixel of one frame, outputs lag the scan by two cycles
    task automatic check_frame();
        int                 p;
        int                 h;
        int                 v;
        int                 guard;
        logic [CHAR_W-1:0]  code;
        logic [COLOR_W-1:0] er;
        logic [COLOR_W-1:0] eg;
        logic [COLOR_W-1:0] eb;
        guard = 0;
        @(negedge pixel_clk);
        while ((scan_cycles % FRAME_CYCLES) != 2 && guard < FRAME_CYCLES + 4) begin
            guard++;
            @(negedge pixel_clk);
        end
        for (int k = 0; k < FRAME_CYCLES; k++) begin
            p = scan_cycles - 2;
            h = p % H_TOTAL;
            v = (p / H_TOTAL) % V_TOTAL;
            er = '0;
            eg = '0;
            eb = '0;
            if (h < H_DISP && v < V_DISP) begin
                code = shadow[(v / CELL_PX) * COLS + h / CELL_PX];
                // leftmost pixel shows the top bit
                if (code[7 - h % CELL_PX]) begin
                    er = FG_R;
                    eg = FG_G;
                    eb = FG_B;
                end else begin
                    er = BG_R;
                    eg = BG_G;
                    eb = BG_B;
                end
            end
            check_colour("vga_r", vga_r, er);
            check_colour("vga_g", vga_g, eg);
            check_colour("vga_b", vga_b, eb);
            check_level("vga_hs", vga_hs,
                        !(h >= H_DISP + H_FRONT && h < H_DISP + H_FRONT + H_SYNC));
            check_level("vga_vs", vga_vs,
                        !(v >= V_DISP + V_FRONT && v < V_DISP + V_FRONT + V_SYNC));
            @(negedge pixel_clk);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        logic [7:0] word_idx;
        logic [3:0] be;
        int         sel;
        seed   = 27268;
        errors = 0;
        checks = 0;
        rst    = 1'b0;
        release_bus();
        for (int i = 0; i < 2 ** VMEM_ADDR_W; i++) begin
            shadow[i] = '0;
        end
        @(posedge pixel_clk);
        @(negedge pixel_clk);
        // outputs idle while reset is held
        check_level("mem_stall", mem_stall, 1'b0);
        check_level("mem_read", mem_read, 1'b0);
        check_level("mem_write", mem_write, 1'b0);
        check_level("vga_hs", vga_hs, 1'b1);
        check_level("vga_vs", vga_vs, 1'b1);
        check_colour("vga_r", vga_r, '0);
        check_colour("vga_g", vga_g, '0);
        check_colour("vga_b", vga_b, '0);
        @(posedge pixel_clk);
        #2;
        rst = 1'b1;
        timer_load();
        for (int i = 0; i < N_STORES; i++) begin
            word_idx = 8'($random(seed) & 7);
            // mostly single-hot, now and then any pattern
            if (i % 6 == 5) begin
                be = 4'($random(seed));
            end else begin
                be = 4'(1 << (($random(seed) & 32'h7fff_ffff) % 4));
            end
            vmem_store(word_idx, be, $random(seed));
            sel = $random(seed) & 3;
            case (sel)
                0, 1:    main_access();
                2:       reserved_access();
                default: timer_load();
            endcase
        end
        release_bus();
        // malformed enable lands on lane 3
        vmem_store(8'd5, 4'b0110, 32'ha1b2_c3d4);
        measure_sync(1'b0, H_SYNC, H_TOTAL);
        measure_sync(1'b1, V_SYNC * H_TOTAL, FRAME_CYCLES);
        check_frame();
        timer_load();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the test sequence completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* tb.f */
logic/vga_text_pkg.sv
logic/vmem_wr_if.sv
logic/mem_port_decode.sv
logic/vmem_write_fsm.sv
logic/video_timing.sv
logic/text_vmem.sv
logic/glyph_render.sv
logic/vga_text_top.sv
sim/vga_text_assertions.sv
sim/tb_vga_text.sv

/* Makefile */
TOP := tb_vga_text
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
